/* program.hex */
// One 16-bit word per entry, the instruction in the low byte; program from word 0, eight per line
// Local data follows at its block RAM word address (local address plus 1876)
0085 0003 0033 00EC 0033 0007 0074 0031
0092 000B 001B 0032 0017 0031 0078 0032
0003 0021 0031 0039 0007 0029 0031 002D
0031 0066 009C 005C 0033 005E 0033 006F
0086 005F 0033 005D 0033 0069 0085 005E
005C 0033 0084 005F 0033 0033 0033 0084
004C 0033 0081 004C
@757
BEEF
@766
0000

/* project.f */
+incdir+include
verilog/apuPkg.sv
verilog/apuControl.sv
verilog/apuExecute.sv
verilog/memRouter.sv
verilog/localBram.sv
verilog/apuSystem.sv
verification/clockGen.sv
verification/apuTb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f project.f --top-module apuTb -o apuTb
	./obj_dir/apuTb | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) && echo "Result: pass" || (echo "Result: fail"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* verification/apuTb.sv */
// Testbench for apuSystem, runs program.hex against an ISA model and checks every external store
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apuTb;
    import apuPkg::*;

    localparam int StepLimit    = 300;  // Model steps, well past the final self loop
    localparam int StoreTimeout = 2000; // Cycles allowed between two external stores
    localparam int SettleCycles = 300;

    logic    clk;
    logic    rst;
    wbReq    extReq;
    wbRsp    extRsp = '0;
    busAddr  obsAddr [$];
    dataWord obsData [$];
    busAddr  expAddr [$];
    dataWord expData [$];
    dataWord extMem [busAddr];   // Contents of the external RAM slave
    dataWord modelExt [busAddr]; // External RAM as the model sees it
    dataWord modelMem [`APU_BRAM_DEPTH];
    wideWord mR0;
    dataWord mR1;
    dataWord mR2;
    dataWord mR3;
    logic    mLess;
    logic    mEqual;
    logic    mGreater;
    pcWord   mPc;

    clockGen clockGen_inst (
        .clk (clk),
        .rst (rst)
    );

    apuSystem apuSystem_inst (
        .clk    (clk),
        .rst    (rst),
        .extRsp (extRsp),
        .extReq (extReq)
    );

    // Unwritten external words read back a pattern built from the full address
    function automatic dataWord fillValue(input busAddr a);
        return a[15:0] ^ a[31:16] ^ {a[7:0], a[15:8]} ^ 16'hA5C3;
    endfunction

    function automatic dataWord slaveRead(input busAddr a);
        return extMem.exists(a) ? extMem[a] : fillValue(a);
    endfunction

    function wideWord modelRead(input regIndex idx);
        case (idx)
            2'd0:    return mR0;
            2'd1:    return {16'h0000, mR1};
            2'd2:    return {16'h0000, mR2};
            default: return {16'h0000, mR3};
        endcase
    endfunction

    function void modelWrite(input regIndex idx, input wideWord v);
        case (idx)
            2'd0:    mR0 = v;
            2'd1:    mR1 = v[15:0]; // Narrow registers drop the upper half
            2'd2:    mR2 = v[15:0];
            default: mR3 = v[15:0];
        endcase
    endfunction

    // Executes one instruction of the model and queues any external store it makes
    function void refStep();
        instrWord   ins;
        logic [3:0] opc;
        regIndex    s1;
        regIndex    s2;
        wideWord    a;
        wideWord    b;
        wideWord    t;
        busAddr     la;
        dataWord    v;
        logic       taken;
        ins = modelMem[mPc[7:0]][7:0];
        mPc = mPc + 8'd1;
        opc = ins[7:4];
        s1  = ins[3:2];
        s2  = ins[1:0];
        a   = modelRead(s1);
        b   = modelRead(s2);
        la  = a + busAddr'(`APU_LOCAL_OFFSET);
        case (opc)
            `APU_OP_ADD: modelWrite(s1, a + b);
            `APU_OP_MUL: begin
                t = a * (wideWord'(1) << `APU_FRAC_BITS); // Scale up by 16
                t = t * b;
                modelWrite(s1, t >> `APU_FRAC_BITS);
            end
            `APU_OP_LOAD: begin
                if (s1 == 2'd0) begin
                    v = modelExt.exists(a) ? modelExt[a] : fillValue(a);
                end else begin
                    v = modelMem[la[10:0]];
                end
                modelWrite(s2, {16'h0000, v});
            end
            `APU_OP_STORE: begin
                if (s1 == 2'd0) begin
                    expAddr.push_back(a);
                    expData.push_back(b[15:0]);
                    modelExt[a] = b[15:0];
                end else begin
                    modelMem[la[10:0]] = b[15:0];
                end
            end
            `APU_OP_JMP: mPc = a[7:0];
            `APU_OP_BRU: begin
                case (s2)
                    2'd0:    taken = mLess;
                    2'd1:    taken = mEqual;
                    2'd2:    taken = mGreater;
                    default: taken = !mEqual;
                endcase
                if (taken) begin
                    mPc = a[7:0];
                end
            end
            `APU_OP_CMP: begin
                mLess    = a < b;
                mEqual   = a == b;
                mGreater = a > b;
            end
            `APU_OP_DEC: begin
                t = {{20{a[11]}}, a[11:0]}; // Signed 12-bit value, doubled
                modelWrite(s1, t << 1);
            end
            default: mR3 = mR3 + {{9{ins[6]}}, ins[6:0]};
        endcase
    endfunction

    task automatic reportFailure();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic checkAddr(input busAddr got, input busAddr exp, input string name);
        if (got !== exp) begin
            $display("ERROR time %0t %s got %h expected %h", $time, name, got, exp);
            reportFailure();
        end
    endtask

    task automatic checkData(input dataWord got, input dataWord exp, input string name);
        if (got !== exp) begin
            $display("ERROR time %0t %s got %h expected %h", $time, name, got, exp);
            reportFailure();
        end
    endtask

    // External RAM slave with 0 to 5 random wait states per access
    initial begin
        int   waitLeft;
        logic busy;
        int unsigned seedDummy;
        seedDummy = $urandom(58);
        busy      = 1'b0;
        waitLeft  = 0;
        forever begin
            @(negedge clk);
            if (rst) begin
                busy = 1'b0;
                extRsp <= '0;
            end else if (extReq.cyc && extReq.stb && !extRsp.ack) begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = int'($urandom % 6);
                end
                if (waitLeft == 0) begin
                    busy = 1'b0;
                    if (extReq.we) begin
                        extMem[extReq.adr] = extReq.datW;
                        obsAddr.push_back(extReq.adr);
                        obsData.push_back(extReq.datW);
                        extRsp <= '{ack: 1'b1, datR: 16'h0000};
                    end else begin
                        extRsp <= '{ack: 1'b1, datR: slaveRead(extReq.adr)};
                    end
                end else begin
                    waitLeft = waitLeft - 1;
                end
            end else begin
                extRsp <= '{ack: 1'b0, datR: 16'h0000}; // Master has dropped the cycle
            end
        end
    end

    // Builds the expected stores, then compares them in order with the observed ones
    initial begin
        int cnt;
        mR0      = '0;
        mR1      = '0;
        mR2      = '0;
        mR3      = '0;
        mLess    = 1'b0;
        mEqual   = 1'b0;
        mGreater = 1'b0;
        mPc      = pcWord'(`APU_PROGRAM_START);
        $readmemh("program.hex", modelMem);
        for (int s = 0; s < StepLimit; s++) begin
            refStep();
        end
        $display("Model expects %0d external stores", expAddr.size());

        cnt = 0;
        while (rst !== 1'b0 && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        if (rst !== 1'b0) begin
            $display("Reset never went low");
            reportFailure();
        end

        for (int i = 0; i < expAddr.size(); i++) begin
            cnt = 0;
            while (obsAddr.size() <= i && cnt < StoreTimeout) begin
                @(posedge clk);
                cnt++;
            end
            if (obsAddr.size() <= i) begin
                $display("Timed out waiting for external store number %0d", i);
                reportFailure();
            end
            checkAddr(obsAddr[i], expAddr[i], "extReq.adr");
            checkData(obsData[i], expData[i], "extReq.datW");
        end

        repeat (SettleCycles) @(posedge clk); // The program now spins in its final jump
        if (obsAddr.size() == expAddr.size()) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Saw %0d external stores but the model made only %0d",
                     obsAddr.size(), expAddr.size());
            reportFailure();
        end
    end

endmodule

`default_nettype wire

/* verification/clockGen.sv */
// Testbench clock and reset source, a 10 ns clock with reset held high for the first two cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk); // Release on the falling edge like every other input
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verilog/apuSystem.sv */
// Top level of the APU subsystem, exposes the external Wishbone port to the testbench or SoC
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apuSystem (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire apuPkg::wbRsp extRsp,
    output apuPkg::wbReq      extReq
);
    import apuPkg::*;

    wbReq     coreReq;
    wbRsp     coreRsp;
    wbReq     bramReq;
    wbRsp     bramRsp;
    opSignals op;
    logic     execStrobe;
    logic     loadAck;
    wideWord  regA;
    wideWord  regB;
    logic     isLess;
    logic     isEqual;
    logic     isGreater;
    logic     isMemOp;
    logic     isExternal;
    logic     isLocalData;

    // Route select is only valid while the latched op is executing
    assign isMemOp     = (op.operation == `APU_OP_LOAD) || (op.operation == `APU_OP_STORE);
    assign isExternal  = execStrobe && isMemOp && (op.src1 == 2'd0);
    assign isLocalData = execStrobe && isMemOp && (op.src1 != 2'd0);

    apuControl apuControl_inst (
        .clk        (clk),
        .rst        (rst),
        .busRsp     (coreRsp),
        .regA       (regA),
        .regB       (regB),
        .isLess     (isLess),
        .isEqual    (isEqual),
        .isGreater  (isGreater),
        .busReq     (coreReq),
        .op         (op),
        .execStrobe (execStrobe),
        .loadAck    (loadAck)
    );

    apuExecute apuExecute_inst (
        .clk        (clk),
        .rst        (rst),
        .op         (op),
        .execStrobe (execStrobe),
        .loadAck    (loadAck),
        .loadData   (coreRsp.datR),
        .regA       (regA),
        .regB       (regB),
        .isLess     (isLess),
        .isEqual    (isEqual),
        .isGreater  (isGreater)
    );

    memRouter memRouter_inst (
        .clk         (clk),
        .rst         (rst),
        .coreReq     (coreReq),
        .bramRsp     (bramRsp),
        .extRsp      (extRsp),
        .isExternal  (isExternal),
        .isLocalData (isLocalData),
        .coreRsp     (coreRsp),
        .bramReq     (bramReq),
        .extReq      (extReq)
    );

    localBram localBram_inst (
        .clk (clk),
        .rst (rst),
        .req (bramReq),
        .rsp (bramRsp)
    );

endmodule

`default_nettype wire

/* verilog/localBram.sv */
// Block RAM slave on Wishbone classic, preloaded from program.hex with the program and local data
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module localBram (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire apuPkg::wbReq req,
    output apuPkg::wbRsp      rsp
);
    import apuPkg::*;

    localparam int AddrBits = $clog2(`APU_BRAM_DEPTH);

    dataWord             mem [`APU_BRAM_DEPTH];
    logic [AddrBits-1:0] wordIdx;
    logic                ackReg;
    dataWord             rdData;

    initial $readmemh("program.hex", mem);

    assign wordIdx = req.adr[AddrBits-1:0];

    // Ack one cycle after stb, and a held strobe sees ack drop between accesses
    always_ff @(posedge clk) begin
        if (rst) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= req.cyc && req.stb && !ackReg;
        end
    end

    always_ff @(posedge clk) begin
        if (req.cyc && req.stb) begin
            if (req.we && !ackReg) begin
                mem[wordIdx] <= req.datW;
            end
            rdData <= mem[wordIdx];
        end
    end

    assign rsp = '{ack: ackReg, datR: rdData};

endmodule

`default_nettype wire

/* verilog/memRouter.sv */
// Splits the core's Wishbone cycles between the local block RAM and the external port
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module memRouter (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire apuPkg::wbReq coreReq,
    input  wire apuPkg::wbRsp bramRsp,
    input  wire apuPkg::wbRsp extRsp,
    input  wire logic         isExternal,  // Load or store with R0 as Source 1
    input  wire logic         isLocalData, // Load or store to the block RAM
    output apuPkg::wbRsp      coreRsp,
    output apuPkg::wbReq      bramReq,
    output apuPkg::wbReq      extReq
);
    import apuPkg::*;

    always_comb begin
        bramReq     = coreReq;
        bramReq.cyc = coreReq.cyc && !isExternal;
        bramReq.stb = coreReq.stb && !isExternal;
        // Fetches use the address as is
        if (isLocalData) begin
            bramReq.adr = coreReq.adr + busAddr'(`APU_LOCAL_OFFSET);
        end

        extReq     = coreReq; // External addresses pass unchanged
        extReq.cyc = coreReq.cyc && isExternal;
        extReq.stb = coreReq.stb && isExternal;
    end

    // Answer comes from whichever slave holds the cycle
    assign coreRsp = isExternal ? extRsp : bramRsp;

    // A slave only answers inside a cycle that was routed to it
    assert property (@(posedge clk) disable iff (rst) bramRsp.ack |-> bramReq.cyc);
    assert property (@(posedge clk) disable iff (rst) extRsp.ack |-> extReq.cyc);

endmodule

`default_nettype wire

/* verilog/apuExecute.sv */
// Register file and ALU of the APU, written during the execute phase of each instruction
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apuExecute (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire apuPkg::opSignals op,
    input  wire logic             execStrobe,
    input  wire logic             loadAck,
    input  wire apuPkg::dataWord  loadData,
    output apuPkg::wideWord       regA,
    output apuPkg::wideWord       regB,
    output logic                  isLess,
    output logic                  isEqual,
    output logic                  isGreater
);
    import apuPkg::*;

    wideWord r0;
    dataWord r1;
    dataWord r2;
    dataWord r3; // Also the accumulator of SET
    logic    wrEn;
    regIndex wrIdx;
    wideWord wrData;
    wideWord mulScaled;
    wideWord mulProduct;
    wideWord decResult;
    dataWord setResult;

    // Narrow registers read back zero-extended
    function automatic wideWord readReg(input regIndex idx, input wideWord w0,
                                        input dataWord w1, input dataWord w2,
                                        input dataWord w3);
        case (idx)
            2'd0:    return w0;
            2'd1:    return wideWord'(w1);
            2'd2:    return wideWord'(w2);
            default: return wideWord'(w3);
        endcase
    endfunction

    assign regA = readReg(op.src1, r0, r1, r2, r3);
    assign regB = readReg(op.src2, r0, r1, r2, r3);

    // Source 1 is scaled up before the product and the result scaled back
    assign mulScaled  = regA << `APU_FRAC_BITS;
    assign mulProduct = mulScaled * regB;
    assign decResult  = {{19{regA[11]}}, regA[11:0], 1'b0};
    assign setResult  = r3 + {{9{op.setImm[6]}}, op.setImm};

    always_comb begin
        wrEn   = 1'b0;
        wrIdx  = op.src1;
        wrData = '0;
        if (execStrobe) begin
            case (op.operation)
                `APU_OP_ADD: begin
                    wrEn   = 1'b1;
                    wrData = regA + regB;
                end
                `APU_OP_MUL: begin
                    wrEn   = 1'b1;
                    wrData = mulProduct >> `APU_FRAC_BITS;
                end
                `APU_OP_LOAD: begin
                    wrEn   = loadAck; // Written on the ack edge only
                    wrIdx  = op.src2;
                    wrData = wideWord'(loadData);
                end
                `APU_OP_DEC: begin
                    wrEn   = 1'b1;
                    wrData = decResult;
                end
                `APU_OP_STORE, `APU_OP_JMP, `APU_OP_BRU, `APU_OP_CMP: begin
                    wrEn = 1'b0;
                end
                default: begin
                    wrEn   = 1'b1;
                    wrIdx  = 2'd3;
                    wrData = wideWord'(setResult);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r0 <= '0;
            r1 <= '0;
            r2 <= '0;
            r3 <= '0;
        end else if (wrEn) begin
            case (wrIdx)
                2'd0:    r0 <= wrData;
                2'd1:    r1 <= dataWord'(wrData); // R1 to R3 keep the low half
                2'd2:    r2 <= dataWord'(wrData);
                default: r3 <= dataWord'(wrData);
            endcase
        end
    end

    // Unsigned compare, flags hold until the next CMP
    always_ff @(posedge clk) begin
        if (rst) begin
            isLess    <= 1'b0;
            isEqual   <= 1'b0;
            isGreater <= 1'b0;
        end else if (execStrobe && (op.operation == `APU_OP_CMP)) begin
            isLess    <= regA < regB;
            isEqual   <= regA == regB;
            isGreater <= regA > regB;
        end
    end

    // Read data from the controller only ever belongs to a load in execute
    assert property (@(posedge clk) disable iff (rst)
        loadAck |-> execStrobe && (op.operation == `APU_OP_LOAD));

endmodule

`default_nettype wire

/* verilog/apuControl.sv */
// Fetch/execute controller of the APU, owns the program counter and the core's Wishbone master
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apuControl (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire apuPkg::wbRsp    busRsp,
    input  wire apuPkg::wideWord regA,
    input  wire apuPkg::wideWord regB,
    input  wire logic            isLess,
    input  wire logic            isEqual,
    input  wire logic            isGreater,
    output apuPkg::wbReq         busReq,
    output apuPkg::opSignals     op,
    output logic                 execStrobe,
    output logic                 loadAck
);
    import apuPkg::*;

    cpuState  state;
    pcWord    pc;          // Points at the instruction being fetched
    instrWord instr;
    logic     started;     // Holds the bus idle for the first cycle out of reset
    logic     isMemOp;
    logic     branchTaken;
    logic     execDone;

    assign op = '{
        operation: instr[7:4],
        src1:      instr[3:2],
        src2:      instr[1:0],
        setImm:    instr[6:0]
    };

    assign isMemOp = (op.operation == `APU_OP_LOAD) || (op.operation == `APU_OP_STORE);

    // ALU, jump and branch finish in one cycle while loads and stores wait for ack
    assign execDone = !isMemOp || busRsp.ack;

    assign execStrobe = (state == execute);
    assign loadAck    = (state == execute) && (op.operation == `APU_OP_LOAD) && busRsp.ack;

    // Branch condition comes from the Source 2 field
    always_comb begin
        case (op.src2)
            2'b00:   branchTaken = isLess;
            2'b01:   branchTaken = isEqual;
            2'b10:   branchTaken = isGreater;
            default: branchTaken = !isEqual;
        endcase
    end

    // Bus outputs follow the state, so they stay put until the slave acks
    always_comb begin
        busReq.cyc  = started && ((state == fetch) || isMemOp);
        busReq.stb  = started && ((state == fetch) || isMemOp);
        busReq.we   = (state == execute) && (op.operation == `APU_OP_STORE);
        busReq.adr  = (state == fetch) ? busAddr'(pc) : busAddr'(regA);
        busReq.datW = dataWord'(regB); // Store data is the low half of Source 2
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= fetch;
            pc      <= pcWord'(`APU_PROGRAM_START);
            instr   <= '0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            case (state)
                fetch: begin
                    if (busReq.cyc && busRsp.ack) begin
                        instr <= busRsp.datR[7:0]; // Instructions live in the low byte
                        pc    <= pc + 8'd1;
                        state <= execute;
                    end
                end
                execute: begin
                    if (execDone) begin
                        state <= fetch;
                        // A taken jump overrides the already advanced counter
                        if ((op.operation == `APU_OP_JMP) ||
                            ((op.operation == `APU_OP_BRU) && branchTaken)) begin
                            pc <= pcWord'(regA);
                        end
                    end
                end
                default: state <= fetch;
            endcase
        end
    end

    // A waiting master keeps its request unchanged until the slave answers
    assert property (@(posedge clk) disable iff (rst)
        busReq.stb && !busRsp.ack |=>
            busReq.stb && $stable(busReq.adr) && $stable(busReq.we) &&
            $stable(busReq.datW));

endmodule

`default_nettype wire

/* verilog/apuPkg.sv */
// Shared APU types for instruction fields, registers, bus addresses and Wishbone links
`default_nettype none

package apuPkg;

    typedef logic [7:0]  instrWord; // Operation, Source 1 / destination, Source 2
    typedef logic [1:0]  regIndex;
    typedef logic [31:0] wideWord;  // R0 and operand width
    typedef logic [15:0] dataWord;  // Bus data width
    typedef logic [31:0] busAddr;
    typedef logic [7:0]  pcWord;

    typedef enum logic {
        fetch,
        execute
    } cpuState;

    // Master side of a Wishbone classic link
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        busAddr  adr;
        dataWord datW;
    } wbReq;

    // Slave side of a Wishbone classic link
    typedef struct packed {
        logic    ack;
        dataWord datR;
    } wbRsp;

    // Decoded fields of the latched instruction
    typedef struct packed {
        logic [3:0] operation;
        regIndex    src1;     // Also the destination register
        regIndex    src2;     // Branch condition for BRU
        logic [6:0] setImm;   // Signed immediate of SET
    } opSignals;

endpackage

`default_nettype wire

/* include/apu_params.svh */
// Opcode, address and memory constants of the APU, included by the RTL modules and the testbench
`ifndef APU_PARAMS_SVH
`define APU_PARAMS_SVH

// Operation field in bits 7:4 of an instruction word
`define APU_OP_ADD   4'b0000
`define APU_OP_MUL   4'b0001
`define APU_OP_LOAD  4'b0010 // Source 1 holds the address, data goes to Source 2
`define APU_OP_STORE 4'b0011 // Source 1 holds the address, data comes from Source 2
`define APU_OP_JMP   4'b0100
`define APU_OP_BRU   4'b0101 // Bits 1:0 pick less, equal, greater or unequal
`define APU_OP_CMP   4'b0110
`define APU_OP_DEC   4'b0111
// Any operation value from 4'b1000 up is SET with a 7-bit signed immediate

// First instruction fetched after reset
`define APU_PROGRAM_START 0

// Local data sits above the program in the block RAM (2048 - 172)
`define APU_LOCAL_OFFSET 1876

// Block RAM size in 16-bit words
`define APU_BRAM_DEPTH 2048

// Fraction bits of the fixed-point multiply
`define APU_FRAC_BITS 4

`endif
